// File: all.f
+incdir+include
src/bus_pkg.sv
src/periph_pkg.sv
src/instruction_bus.sv
src/data_bus.sv
src/sram_controller.sv
src/bootrom_controller.sv
src/periph_regs.sv
src/thinpad_soc.sv
tests/soc_checker.sv
tests/soc_tb.sv

// File: include/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// shared ram window
`define RAM_BASE      32'h8000_0000
`define RAM_SIZE      32'h0040_0000

// boot rom, 64 bytes
`define ROM_BASE      32'h1FC0_0000
`define ROM_WORDS     16
`define ROM_MAGIC     32'h3C08_BFD0

// peripheral registers
`define TIMER_ADDR    32'hBFD0_0100
`define GPIO_OUT_ADDR 32'hBFD0_0200
`define GPIO_IN_ADDR  32'hBFD0_0204

`endif

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module soc_tb -o soc_sim

./obj_dir/soc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test OK" sim.log; then
    exit 0
fi
exit 1

// File: src/bootrom_controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_defs.svh"

module bootrom_controller (
    input  logic           clk,
    input  logic [3:0]     index,
    output bus_pkg::word_t rdata
);

    bus_pkg::word_t rom_table [`ROM_WORDS];

    // contents derived from the word index
    always_comb begin
        for (int i = 0; i < `ROM_WORDS; i++) begin
            rom_table[i] = `ROM_MAGIC ^ bus_pkg::word_t'(i);
        end
    end

    always_ff @(posedge clk) begin
        rdata <= rom_table[index];  // one cycle latency
    end

endmodule

`default_nettype wire

// File: src/bus_pkg.sv
`default_nettype none

package bus_pkg;

    typedef logic [31:0] addr_t;       // byte address
    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_t;
    typedef logic [19:0] sram_addr_t;  // word address, 4 MB of RAM

    // cpu side request, also used from decoder to target
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
        be_t   be;
    } bus_req_t;

    typedef struct packed {
        logic  stall;   // combinational
        logic  rvalid;  // one cycle after acceptance
        word_t rdata;
    } bus_rsp_t;

    // external sram pins, active high strobes
    typedef struct packed {
        logic       ce;
        logic       we;
        sram_addr_t addr;
        word_t      wdata;
        be_t        be;
    } sram_req_t;

endpackage

`default_nettype wire

// File: src/data_bus.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_defs.svh"

module data_bus (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::bus_req_t cpu_req,
    output bus_pkg::bus_rsp_t cpu_rsp,
    output bus_pkg::bus_req_t ram_req,
    input  bus_pkg::word_t    ram_rdata,
    output bus_pkg::bus_req_t periph_req,
    input  bus_pkg::word_t    periph_rdata
);

    logic                 rvalid_q;
    logic                 is_periph;
    periph_pkg::dtarget_t tgt_d;
    periph_pkg::dtarget_t tgt_q;

    always_comb begin
        if ((cpu_req.addr & ~(`RAM_SIZE - 1)) == `RAM_BASE) begin
            tgt_d = periph_pkg::TGT_RAM;
        end else if (cpu_req.addr == `TIMER_ADDR) begin
            tgt_d = periph_pkg::TGT_TIMER;
        end else if (cpu_req.addr == `GPIO_OUT_ADDR || cpu_req.addr == `GPIO_IN_ADDR) begin
            tgt_d = periph_pkg::TGT_GPIO;
        end else begin
            tgt_d = periph_pkg::TGT_NONE;  // unmapped
        end
    end

    // timer and gpio share one port, periph_regs picks the register
    assign is_periph = (tgt_d == periph_pkg::TGT_TIMER) || (tgt_d == periph_pkg::TGT_GPIO);

    always_comb begin
        ram_req          = cpu_req;
        ram_req.valid    = cpu_req.valid && (tgt_d == periph_pkg::TGT_RAM);
        periph_req       = cpu_req;
        periph_req.valid = cpu_req.valid && is_periph;
    end

    // data port is never stalled, so every valid is accepted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            tgt_q    <= periph_pkg::TGT_NONE;
        end else begin
            rvalid_q <= cpu_req.valid && !cpu_req.write;
            if (cpu_req.valid) tgt_q <= tgt_d;
        end
    end

    always_comb begin
        cpu_rsp.stall  = 1'b0;
        cpu_rsp.rvalid = rvalid_q;
        case (tgt_q)
            periph_pkg::TGT_RAM:   cpu_rsp.rdata = ram_rdata;
            periph_pkg::TGT_TIMER: cpu_rsp.rdata = periph_rdata;
            periph_pkg::TGT_GPIO:  cpu_rsp.rdata = periph_rdata;
            default:               cpu_rsp.rdata = '0;  // unmapped reads as zero
        endcase
    end

endmodule

`default_nettype wire

// File: src/instruction_bus.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_defs.svh"

module instruction_bus (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::bus_req_t cpu_req,
    output bus_pkg::bus_rsp_t cpu_rsp,
    output bus_pkg::bus_req_t ram_req,
    input  logic              ram_stall,
    input  bus_pkg::word_t    ram_rdata,
    output logic [3:0]        rom_index,
    input  bus_pkg::word_t    rom_rdata
);

    logic                 is_ram;
    logic                 stall;
    logic                 accept;
    logic                 rvalid_q;
    periph_pkg::dtarget_t tgt_d;
    periph_pkg::dtarget_t tgt_q;

    // anything outside the ram window fetches from rom
    assign is_ram = (cpu_req.addr & ~(`RAM_SIZE - 1)) == `RAM_BASE;
    assign tgt_d  = is_ram ? periph_pkg::TGT_RAM : periph_pkg::TGT_ROM;

    assign stall     = ram_stall && cpu_req.valid && is_ram;
    assign accept    = cpu_req.valid && !stall;
    assign rom_index = cpu_req.addr[5:2];

    always_comb begin
        ram_req       = cpu_req;
        ram_req.valid = cpu_req.valid && is_ram;
        ram_req.write = 1'b0;  // fetch port is read only
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            tgt_q    <= periph_pkg::TGT_ROM;
        end else begin
            rvalid_q <= accept;
            if (accept) tgt_q <= tgt_d;
        end
    end

    always_comb begin
        cpu_rsp.stall  = stall;
        cpu_rsp.rvalid = rvalid_q;
        cpu_rsp.rdata  = (tgt_q == periph_pkg::TGT_RAM) ? ram_rdata : rom_rdata;
    end

endmodule

`default_nettype wire

// File: src/periph_pkg.sv
`default_nettype none

package periph_pkg;

    // target of an accepted request, kept for the read data cycle
    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_ROM,
        TGT_TIMER,
        TGT_GPIO
    } dtarget_t;

    // port that gets the next sram read word
    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_INST,
        OWN_DATA
    } sram_owner_t;

    typedef logic [15:0] gpio_t;
    typedef logic [31:0] count_t;

endpackage

`default_nettype wire

// File: src/periph_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_defs.svh"

module periph_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::word_t    rdata,
    output periph_pkg::gpio_t gpio_out,
    input  periph_pkg::gpio_t gpio_in
);

    logic               timer_hit;
    logic               gpio_out_hit;
    logic               gpio_in_hit;
    logic               rd;
    logic               wr;
    periph_pkg::count_t count_q;
    periph_pkg::count_t count_d;

    assign timer_hit    = req.addr == `TIMER_ADDR;
    assign gpio_out_hit = req.addr == `GPIO_OUT_ADDR;
    assign gpio_in_hit  = req.addr == `GPIO_IN_ADDR;

    // byte enables are ignored here
    assign wr = req.valid && req.write;
    assign rd = req.valid && !req.write;

    // free running, a write loads the count
    assign count_d = (wr && timer_hit) ? req.wdata : count_q + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q  <= '0;
            gpio_out <= '0;
        end else begin
            count_q <= count_d;
            if (wr && gpio_out_hit) gpio_out <= req.wdata[15:0];
        end
    end

    // timer read gives the value taken at the acceptance edge
    always_ff @(posedge clk) begin
        if (rd) begin
            if (timer_hit) begin
                rdata <= count_d;
            end else if (gpio_out_hit) begin
                rdata <= {16'b0, gpio_out};
            end else if (gpio_in_hit) begin
                rdata <= {16'b0, gpio_in};
            end else begin
                rdata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/sram_controller.sv
`timescale 1ns/1ps
`default_nettype none

module sram_controller (
    input  logic               clk,
    input  logic               rst_n,
    input  bus_pkg::bus_req_t  inst_req,
    input  bus_pkg::bus_req_t  data_req,
    output logic               inst_stall,
    output bus_pkg::word_t     inst_rdata,
    output bus_pkg::word_t     data_rdata,
    output bus_pkg::sram_req_t sram,
    input  bus_pkg::word_t     sram_rdata
);

    logic                    data_go;
    logic                    inst_go;
    bus_pkg::bus_req_t       sel;
    periph_pkg::sram_owner_t owner_d;
    periph_pkg::sram_owner_t owner_q;

    // data port always wins
    assign data_go    = data_req.valid;
    assign inst_go    = inst_req.valid && !data_req.valid;
    assign inst_stall = inst_req.valid && data_req.valid;

    assign sel = data_go ? data_req : inst_req;

    always_comb begin
        sram.ce    = data_go || inst_go;
        sram.we    = sram.ce && sel.write;
        sram.addr  = sel.addr[21:2];
        sram.wdata = sel.wdata;
        // full word on reads
        sram.be    = sel.write ? sel.be : 4'hF;
    end

    always_comb begin
        if (!sram.ce || sram.we) begin
            owner_d = periph_pkg::OWN_IDLE;
        end else if (data_go) begin
            owner_d = periph_pkg::OWN_DATA;
        end else begin
            owner_d = periph_pkg::OWN_INST;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_q <= periph_pkg::OWN_IDLE;
        end else begin
            owner_q <= owner_d;
        end
    end

    // sram returns the word one cycle after ce
    assign inst_rdata = (owner_q == periph_pkg::OWN_INST) ? sram_rdata : '0;
    assign data_rdata = (owner_q == periph_pkg::OWN_DATA) ? sram_rdata : '0;

endmodule

`default_nettype wire

// File: src/thinpad_soc.sv
`timescale 1ns/1ps
`default_nettype none

module thinpad_soc (
    input  logic               clk,
    input  logic               rst_n,
    input  bus_pkg::bus_req_t  ibus_req,
    input  bus_pkg::bus_req_t  dbus_req,
    output bus_pkg::bus_rsp_t  ibus_rsp,
    output bus_pkg::bus_rsp_t  dbus_rsp,
    output bus_pkg::sram_req_t sram,
    input  bus_pkg::word_t     sram_rdata,
    output periph_pkg::gpio_t  gpio_out,
    input  periph_pkg::gpio_t  gpio_in
);

    bus_pkg::bus_req_t ram_inst_req;
    bus_pkg::bus_req_t ram_data_req;
    bus_pkg::bus_req_t periph_req;
    bus_pkg::word_t    ram_inst_rdata;
    bus_pkg::word_t    ram_data_rdata;
    bus_pkg::word_t    periph_rdata;
    bus_pkg::word_t    rom_rdata;
    logic              inst_stall;
    logic [3:0]        rom_index;

    instruction_bus instruction_bus0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (ibus_req),
        .cpu_rsp   (ibus_rsp),
        .ram_req   (ram_inst_req),
        .ram_stall (inst_stall),
        .ram_rdata (ram_inst_rdata),
        .rom_index (rom_index),
        .rom_rdata (rom_rdata)
    );

    data_bus data_bus0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (dbus_req),
        .cpu_rsp      (dbus_rsp),
        .ram_req      (ram_data_req),
        .ram_rdata    (ram_data_rdata),
        .periph_req   (periph_req),
        .periph_rdata (periph_rdata)
    );

    sram_controller sram_controller0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_req   (ram_inst_req),
        .data_req   (ram_data_req),
        .inst_stall (inst_stall),
        .inst_rdata (ram_inst_rdata),
        .data_rdata (ram_data_rdata),
        .sram       (sram),
        .sram_rdata (sram_rdata)
    );

    bootrom_controller bootrom_controller0 (
        .clk   (clk),
        .index (rom_index),
        .rdata (rom_rdata)
    );

    periph_regs periph_regs0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (periph_req),
        .rdata    (periph_rdata),
        .gpio_out (gpio_out),
        .gpio_in  (gpio_in)
    );

endmodule

`default_nettype wire

// File: tests/soc_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_defs.svh"

module soc_checker (
    input logic               clk,
    input logic               rst_n,
    input bus_pkg::bus_req_t  ibus_req,
    input bus_pkg::bus_req_t  dbus_req,
    input bus_pkg::bus_rsp_t  ibus_rsp,
    input bus_pkg::bus_rsp_t  dbus_rsp,
    input bus_pkg::sram_req_t sram,
    input logic               inst_stall
);

    logic dbus_in_ram;

    // data port address inside the ram window
    assign dbus_in_ram = (dbus_req.addr & ~(`RAM_SIZE - 1)) == `RAM_BASE;

    // rvalid only one cycle after an accepted read
    assert property (@(posedge clk) disable iff (!rst_n)
        ibus_rsp.rvalid |-> $past(ibus_req.valid && !ibus_rsp.stall))
        else $error("ibus rvalid without an accepted fetch");

    assert property (@(posedge clk) disable iff (!rst_n)
        dbus_rsp.rvalid |-> $past(dbus_req.valid && !dbus_rsp.stall && !dbus_req.write))
        else $error("dbus rvalid without an accepted read");

    assert property (@(posedge clk) disable iff (!rst_n)
        inst_stall |-> (dbus_req.valid && dbus_in_ram))
        else $error("fetch stalled with no data ram request");

    assert property (@(posedge clk) $past(!rst_n) |-> !sram.ce)
        else $error("sram ce high right after reset");

    // held fetch must not change while stalled
    assert property (@(posedge clk) disable iff (!rst_n)
        (ibus_req.valid && ibus_rsp.stall) |=> $stable(ibus_req))
        else $error("stalled fetch request changed");

endmodule

bind thinpad_soc soc_checker chk0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .ibus_req   (ibus_req),
    .dbus_req   (dbus_req),
    .ibus_rsp   (ibus_rsp),
    .dbus_rsp   (dbus_rsp),
    .sram       (sram),
    .inst_stall (inst_stall)
);

`default_nettype wire

// File: tests/soc_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_defs.svh"

module soc_tb;

    logic clk = 0;
    logic rst_n;
    bus_pkg::bus_req_t ibus_req, dbus_req;
    bus_pkg::bus_rsp_t ibus_rsp, dbus_rsp;
    bus_pkg::sram_req_t sram;
    bus_pkg::word_t sram_rdata;
    periph_pkg::gpio_t gpio_out, gpio_in, gpio_ref;
    bus_pkg::word_t sram_mem [bus_pkg::sram_addr_t];
    bus_pkg::word_t ref_mem [bus_pkg::sram_addr_t];
    bus_pkg::word_t exp_i_q [$];
    bus_pkg::word_t exp_d_q [$];
    bus_pkg::word_t exp_i_head, exp_d_head, timer_v, v, d;
    logic exp_i_ok, exp_d_ok, failed, done;
    logic [31:0] lfsr;
    int cycle, timer_cycle, n_acc_i, n_rv_i, n_acc_d, n_rv_d, k;
    bus_pkg::addr_t a;
    bus_pkg::addr_t ra;  // address seen by the reference model
    bus_pkg::be_t be;

    thinpad_soc dut0 (.clk(clk), .rst_n(rst_n), .ibus_req(ibus_req), .dbus_req(dbus_req),
        .ibus_rsp(ibus_rsp), .dbus_rsp(dbus_rsp), .sram(sram), .sram_rdata(sram_rdata),
        .gpio_out(gpio_out), .gpio_in(gpio_in));

    always #50 clk = ~clk;

    function automatic bus_pkg::word_t fill(bus_pkg::sram_addr_t w);
        return {~w[11:0], w};  // untouched sram words
    endfunction

    function automatic bus_pkg::word_t merge(bus_pkg::word_t old, bus_pkg::word_t nw,
                                             bus_pkg::be_t en);
        for (int b = 0; b < 4; b++) begin
            if (en[b]) old[8*b +: 8] = nw[8*b +: 8];
        end
        return old;
    endfunction

    function automatic bus_pkg::word_t ref_word(bus_pkg::sram_addr_t w);
        return ref_mem.exists(w) ? ref_mem[w] : fill(w);
    endfunction

    function automatic logic in_ram(bus_pkg::addr_t x);
        return (x & ~(`RAM_SIZE - 1)) == `RAM_BASE;
    endfunction

    task automatic abort_run(input string msg);
        failed = 1;
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // single port sram, one cycle read latency
    always @(posedge clk) begin
        if (sram.ce && sram.we) begin
            sram_mem[sram.addr] = merge(sram_mem.exists(sram.addr) ? sram_mem[sram.addr]
                                        : fill(sram.addr), sram.wdata, sram.be);
        end else if (sram.ce) begin
            sram_rdata <= sram_mem.exists(sram.addr) ? sram_mem[sram.addr] : fill(sram.addr);
        end
    end

    // reference model, predicts each read at its acceptance edge
    always @(posedge clk) begin
        cycle++;
        if (ibus_rsp.rvalid) begin
            n_rv_i++;
            if (exp_i_q.size() > 0) void'(exp_i_q.pop_front());
        end
        if (dbus_rsp.rvalid) begin
            n_rv_d++;
            if (exp_d_q.size() > 0) void'(exp_d_q.pop_front());
        end
        if (rst_n && ibus_req.valid && !ibus_rsp.stall) begin
            n_acc_i++;
            exp_i_q.push_back(in_ram(ibus_req.addr) ? ref_word(ibus_req.addr[21:2])
                              : `ROM_MAGIC ^ bus_pkg::word_t'(ibus_req.addr[5:2]));
        end
        if (rst_n && dbus_req.valid && !dbus_rsp.stall) begin
            n_acc_d++;
            ra = dbus_req.addr;
            if (dbus_req.write && in_ram(ra)) begin
                ref_mem[ra[21:2]] = merge(ref_word(ra[21:2]), dbus_req.wdata, dbus_req.be);
            end else if (dbus_req.write && ra == `TIMER_ADDR) begin
                timer_v = dbus_req.wdata;
                timer_cycle = cycle;
            end else if (dbus_req.write && ra == `GPIO_OUT_ADDR) begin
                gpio_ref = dbus_req.wdata[15:0];
            end else if (!dbus_req.write) begin
                if (in_ram(ra)) exp_d_q.push_back(ref_word(ra[21:2]));
                else if (ra == `TIMER_ADDR) exp_d_q.push_back(timer_v + (cycle - timer_cycle));
                else if (ra == `GPIO_OUT_ADDR) exp_d_q.push_back({16'b0, gpio_ref});
                else if (ra == `GPIO_IN_ADDR) exp_d_q.push_back({16'b0, gpio_in});
                else exp_d_q.push_back('0);  // unmapped
            end
        end
        exp_i_ok = exp_i_q.size() > 0;
        exp_i_head = exp_i_ok ? exp_i_q[0] : '0;
        exp_d_ok = exp_d_q.size() > 0;
        exp_d_head = exp_d_ok ? exp_d_q[0] : '0;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        ibus_rsp.rvalid |-> (exp_i_ok && ibus_rsp.rdata == exp_i_head))
        else abort_run($sformatf("FAIL %0t: ibus read data does not match", $time));

    assert property (@(posedge clk) disable iff (!rst_n)
        dbus_rsp.rvalid |-> (exp_d_ok && dbus_rsp.rdata == exp_d_head))
        else abort_run($sformatf("FAIL %0t: dbus read data does not match", $time));

    // data port has no back-pressure
    assert property (@(posedge clk) disable iff (!rst_n) !dbus_rsp.stall)
        else abort_run($sformatf("FAIL %0t: dbus stall is high", $time));

    assert property (@(posedge clk) disable iff (!rst_n) gpio_out == gpio_ref)
        else abort_run($sformatf("FAIL %0t: gpio_out differs from last write", $time));

    task automatic data_access(input logic wr, input bus_pkg::addr_t ad,
                               input bus_pkg::word_t wd, input bus_pkg::be_t en);
        int acc0;
        int rv0;
        int t;
        @(posedge clk);
        #1;
        dbus_req = '{valid: 1'b1, write: wr, addr: ad, wdata: wd, be: en};
        acc0 = n_acc_d;
        rv0 = n_rv_d;
        for (t = 0; n_acc_d == acc0; t++) begin
            if (t > 20) abort_run("data request was never accepted");
            @(posedge clk);
            #1;
        end
        dbus_req.valid = 1'b0;
        for (t = 0; !wr && n_rv_d == rv0; t++) begin
            if (t > 20) abort_run("data read never returned rvalid");
            @(posedge clk);
            #1;
        end
    endtask

    task automatic fetch(input bus_pkg::addr_t ad);
        int acc0;
        int rv0;
        int t;
        @(posedge clk);
        #1;
        ibus_req = '{valid: 1'b1, write: 1'b0, addr: ad, wdata: '0, be: 4'hF};
        acc0 = n_acc_i;
        rv0 = n_rv_i;
        for (t = 0; n_acc_i == acc0; t++) begin
            if (t > 20) abort_run("instruction fetch was never accepted");
            @(posedge clk);
            #1;
        end
        ibus_req.valid = 1'b0;
        for (t = 0; n_rv_i == rv0; t++) begin
            if (t > 20) abort_run("instruction fetch never returned rvalid");
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        rst_n = 0;
        ibus_req = '0;
        dbus_req = '0;
        gpio_in = '0;
        gpio_ref = '0;
        sram_rdata = '0;
        lfsr = 32'h381a;
        failed = 0;
        done = 0;
        timer_v = '0;
        cycle = 0;
        timer_cycle = 0;
        n_acc_i = 0;
        n_rv_i = 0;
        n_acc_d = 0;
        n_rv_d = 0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 12; i++) begin  // boot rom
            v = rand_bits(4);
            fetch(`ROM_BASE + {v[3:0], 2'b00});
        end
        for (int i = 0; i < 16; i++) begin  // ram through both ports
            v = rand_bits(6);
            a = `RAM_BASE | {v[5:0], 2'b00};
            d = rand_bits(32);
            v = rand_bits(4);
            data_access(1'b1, a, d, v[3:0]);
            data_access(1'b0, a, '0, 4'hF);
            fetch(a);
        end
        d = rand_bits(32);
        fork  // data port wins, fetch stalls
            data_access(1'b1, `RAM_BASE + 32'h40, d, 4'hF);
            fetch(`RAM_BASE + 32'h40);
        join
        fork
            data_access(1'b0, `RAM_BASE + 32'h40, '0, 4'hF);
            fetch(`RAM_BASE + 32'h44);
        join
        d = rand_bits(32);
        v = rand_bits(3);
        k = v + 1;
        data_access(1'b1, `TIMER_ADDR, d, 4'h0);
        repeat (k) @(posedge clk);
        data_access(1'b0, `TIMER_ADDR, '0, 4'h0);
        d = rand_bits(16);
        data_access(1'b1, `GPIO_OUT_ADDR, d, 4'hF);
        data_access(1'b0, `GPIO_OUT_ADDR, '0, 4'hF);
        v = rand_bits(16);
        gpio_in = v[15:0];
        data_access(1'b0, `GPIO_IN_ADDR, '0, 4'hF);
        data_access(1'b1, 32'h4000_0010, 32'hDEAD_BEEF, 4'hF);  // unmapped
        data_access(1'b0, 32'h4000_0010, '0, 4'hF);
        data_access(1'b0, `RAM_BASE + 32'h10, '0, 4'hF);
        repeat (3) @(posedge clk);
        if (exp_i_q.size() == 0 && exp_d_q.size() == 0 && !failed) begin
            done = 1;
            $display("Test OK");
            $finish;
        end else begin
            abort_run("expected read data never arrived");
        end
    end

    final begin
        if (!done && !failed) $display("Test FAILED");
    end

endmodule

`default_nettype wire
